//--- src/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  localparam int XLEN = 32;
  typedef logic [XLEN-1:0] word_t;

  localparam int REG_AW = 5;
  typedef logic [REG_AW-1:0] reg_idx_t;

  // Major opcodes of the RV32I base set
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_LUI    = 7'b0110111;

  // ====================
  // Instruction formats, MSB first
  // ====================
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // Branch offset bits are scattered, bit 0 is implied zero
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_t;

endpackage

`default_nettype wire

//--- src/rv_ctrl_pkg.sv
`default_nettype none

package rv_ctrl_pkg;

  // ALU operation codes
  localparam int ALU_OP_W = 4;
  localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd7;
  localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd8;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd9;
  localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10;
  localparam logic [ALU_OP_W-1:0] ALU_LINK   = 4'd11;

  // Branch conditions
  localparam int BR_OP_W = 3;
  localparam logic [BR_OP_W-1:0] BR_NONE = 3'd0;
  localparam logic [BR_OP_W-1:0] BR_EQ   = 3'd1;
  localparam logic [BR_OP_W-1:0] BR_NE   = 3'd2;
  localparam logic [BR_OP_W-1:0] BR_LT   = 3'd3;
  localparam logic [BR_OP_W-1:0] BR_GE   = 3'd4;
  localparam logic [BR_OP_W-1:0] BR_LTU  = 3'd5;
  localparam logic [BR_OP_W-1:0] BR_GEU  = 3'd6;

  // Operand source for execute
  localparam int FWD_W = 2;
  localparam logic [FWD_W-1:0] FWD_REG = 2'd0;
  localparam logic [FWD_W-1:0] FWD_MEM = 2'd1;
  localparam logic [FWD_W-1:0] FWD_WB  = 2'd2;

  // addi x0, x0, 0
  localparam logic [31:0] NOP_WORD = 32'h0000_0013;

endpackage

`default_nettype wire

//--- src/rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_isa_pkg::reg_idx_t rs1,
  input  rv_isa_pkg::reg_idx_t rs2,
  input  rv_isa_pkg::reg_idx_t rd,
  input  rv_isa_pkg::word_t    rd_data,
  input  logic                 we,
  output rv_isa_pkg::word_t    rs1_data,
  output rv_isa_pkg::word_t    rs2_data
);
  import rv_isa_pkg::*;

  // x0 has no storage
  word_t regs [1:2**REG_AW-1];

  // Read priority is zero index before write-through before storage
  function automatic word_t read_port(input reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end else if (we && idx == rd) begin
      return rd_data;
    end
    return regs[idx];
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 2**REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[rd] <= rd_data;
    end
  end

  always_comb begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

  a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
    !(we && rd == '0));

endmodule

`default_nettype wire

//--- src/rv_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decoder (
  input  rv_isa_pkg::inst_t                inst,
  output rv_isa_pkg::reg_idx_t             rd,
  output rv_isa_pkg::reg_idx_t             rs1,
  output rv_isa_pkg::reg_idx_t             rs2,
  output rv_isa_pkg::word_t                imm,
  output logic [rv_ctrl_pkg::ALU_OP_W-1:0] alu_op,
  output logic [rv_ctrl_pkg::BR_OP_W-1:0]  br_op,
  output logic                             use_imm,
  output logic                             a_is_pc,
  output logic                             reg_we,
  output logic                             mem_rd,
  output logic                             mem_we,
  output logic                             is_jump,
  output logic                             is_jalr,
  output logic                             is_ecall
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic [6:0] funct7;
  logic [2:0] funct3;
  logic       valid;

  // alt selects SUB over ADD and SRA over SRL
  function automatic logic [ALU_OP_W-1:0] alu_from_f3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign funct7 = inst.r_fmt.funct7;
  assign funct3 = inst.r_fmt.funct3;

  always_comb begin
    rd       = inst.r_fmt.rd;
    rs1      = '0;
    rs2      = '0;
    imm      = '0;
    alu_op   = ALU_ADD;
    br_op    = BR_NONE;
    use_imm  = 1'b0;
    a_is_pc  = 1'b0;
    reg_we   = 1'b0;
    mem_rd   = 1'b0;
    mem_we   = 1'b0;
    is_jump  = 1'b0;
    is_jalr  = 1'b0;
    is_ecall = 1'b0;
    valid    = 1'b1;
    case (inst.r_fmt.opcode)
      OP_REG: begin
        rs1    = inst.r_fmt.rs1;
        rs2    = inst.r_fmt.rs2;
        reg_we = 1'b1;
        alu_op = alu_from_f3(funct3, funct7[5]);
        valid  = funct7 == 7'h00 ||
                 (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      OP_IMM: begin
        rs1     = inst.i_fmt.rs1;
        imm     = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
        use_imm = 1'b1;
        reg_we  = 1'b1;
        // Only the shifts carry a funct7, ADDI has no subtract form
        alu_op  = alu_from_f3(funct3, funct3 == 3'b101 && funct7[5]);
        if (funct3 == 3'b001) begin
          valid = funct7 == 7'h00;
        end else if (funct3 == 3'b101) begin
          valid = funct7 == 7'h00 || funct7 == 7'h20;
        end
      end
      OP_LOAD: begin
        rs1     = inst.i_fmt.rs1;
        imm     = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
        use_imm = 1'b1;
        reg_we  = 1'b1;
        mem_rd  = 1'b1;
        valid   = funct3 == 3'b010;
      end
      OP_STORE: begin
        rs1     = inst.s_fmt.rs1;
        rs2     = inst.s_fmt.rs2;
        imm     = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
        use_imm = 1'b1;
        mem_we  = 1'b1;
        valid   = funct3 == 3'b010;
      end
      OP_BRANCH: begin
        rs1 = inst.b_fmt.rs1;
        rs2 = inst.b_fmt.rs2;
        imm = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
               inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
        case (funct3)
          3'b000:  br_op = BR_EQ;
          3'b001:  br_op = BR_NE;
          3'b100:  br_op = BR_LT;
          3'b101:  br_op = BR_GE;
          3'b110:  br_op = BR_LTU;
          3'b111:  br_op = BR_GEU;
          default: valid = 1'b0;
        endcase
      end
      OP_JAL: begin
        imm     = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                   inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
        alu_op  = ALU_LINK;
        a_is_pc = 1'b1;
        reg_we  = 1'b1;
        is_jump = 1'b1;
      end
      OP_JALR: begin
        rs1     = inst.i_fmt.rs1;
        imm     = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
        alu_op  = ALU_LINK;
        a_is_pc = 1'b1;
        reg_we  = 1'b1;
        is_jump = 1'b1;
        is_jalr = 1'b1;
        valid   = funct3 == 3'b000;
      end
      OP_LUI: begin
        imm     = {inst.u_fmt.imm, 12'h000};
        alu_op  = ALU_PASS_B;
        use_imm = 1'b1;
        reg_we  = 1'b1;
      end
      OP_AUIPC: begin
        imm     = {inst.u_fmt.imm, 12'h000};
        use_imm = 1'b1;
        a_is_pc = 1'b1;
        reg_we  = 1'b1;
      end
      OP_SYSTEM: begin
        is_ecall = inst == 32'h0000_0073;
        valid    = is_ecall;
      end
      default: valid = 1'b0;
    endcase

    // Unknown encodings become bubbles
    if (!valid) begin
      rs1     = '0;
      rs2     = '0;
      br_op   = BR_NONE;
      reg_we  = 1'b0;
      mem_rd  = 1'b0;
      mem_we  = 1'b0;
      is_jump = 1'b0;
      is_jalr = 1'b0;
    end
    // Nothing ever writes x0, a load to x0 is dropped as well
    if (rd == '0) begin
      reg_we = 1'b0;
      mem_rd = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- src/rv_alu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_alu (
  input  rv_isa_pkg::word_t                op_a,
  input  rv_isa_pkg::word_t                op_b,
  input  rv_isa_pkg::word_t                cmp_a,
  input  rv_isa_pkg::word_t                cmp_b,
  input  logic [rv_ctrl_pkg::ALU_OP_W-1:0] alu_op,
  input  logic [rv_ctrl_pkg::BR_OP_W-1:0]  br_op,
  output rv_isa_pkg::word_t                result,
  output logic                             take_branch
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic [4:0] shamt;

  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:    result = op_a + op_b;
      ALU_SUB:    result = op_a - op_b;
      ALU_AND:    result = op_a & op_b;
      ALU_OR:     result = op_a | op_b;
      ALU_XOR:    result = op_a ^ op_b;
      ALU_SLL:    result = op_a << shamt;
      ALU_SRL:    result = op_a >> shamt;
      ALU_SRA:    result = $signed(op_a) >>> shamt;
      ALU_SLT:    result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   result = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_PASS_B: result = op_b;
      ALU_LINK:   result = op_a + 32'd4;
      default:    result = '0;
    endcase
  end

  // Compares the register operands, never the immediate
  always_comb begin
    case (br_op)
      BR_EQ:   take_branch = cmp_a == cmp_b;
      BR_NE:   take_branch = cmp_a != cmp_b;
      BR_LT:   take_branch = $signed(cmp_a) < $signed(cmp_b);
      BR_GE:   take_branch = $signed(cmp_a) >= $signed(cmp_b);
      BR_LTU:  take_branch = cmp_a < cmp_b;
      BR_GEU:  take_branch = cmp_a >= cmp_b;
      default: take_branch = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/rv_hazard.sv
`timescale 1ns/10ps
`default_nettype none

module rv_hazard (
  input  rv_isa_pkg::reg_idx_t          d_rs1,
  input  rv_isa_pkg::reg_idx_t          d_rs2,
  input  rv_isa_pkg::reg_idx_t          x_rs1,
  input  rv_isa_pkg::reg_idx_t          x_rs2,
  input  rv_isa_pkg::reg_idx_t          x_rd,
  input  rv_isa_pkg::reg_idx_t          m_rd,
  input  rv_isa_pkg::reg_idx_t          w_rd,
  input  logic                          x_mem_rd,
  input  logic                          m_reg_we,
  input  logic                          w_reg_we,
  input  logic                          redirect,
  output logic [rv_ctrl_pkg::FWD_W-1:0] fwd_a,
  output logic [rv_ctrl_pkg::FWD_W-1:0] fwd_b,
  output logic                          stall,
  output logic                          flush_d,
  output logic                          flush_x
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic load_use;

  // Memory beats writeback as the younger producer
  function automatic logic [FWD_W-1:0] fwd_sel(input reg_idx_t rs);
    if (m_reg_we && m_rd == rs) begin
      return FWD_MEM;
    end else if (w_reg_we && w_rd == rs) begin
      return FWD_WB;
    end
    return FWD_REG;
  endfunction

  always_comb begin
    fwd_a    = fwd_sel(x_rs1);
    fwd_b    = fwd_sel(x_rs2);
    load_use = x_mem_rd && (x_rd == d_rs1 || x_rd == d_rs2);
    // The redirect discards the waiting consumer anyway
    stall    = load_use && !redirect;
    flush_d  = redirect;
    flush_x  = redirect || load_use;
  end

endmodule

`default_nettype wire

//--- src/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core #(
  parameter rv_isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic              clk,
  input  logic              rst,
  output rv_isa_pkg::word_t imem_addr,
  input  rv_isa_pkg::word_t imem_data,
  output rv_isa_pkg::word_t dmem_addr,
  output rv_isa_pkg::word_t dmem_wdata,
  output logic              dmem_we,
  input  rv_isa_pkg::word_t dmem_rdata,
  output logic              halt,
  output rv_isa_pkg::word_t trace_pc,
  output rv_isa_pkg::word_t trace_inst
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  function automatic word_t fwd_mux(input logic [FWD_W-1:0] sel, input word_t reg_val,
                                    input word_t mem_val, input word_t wb_val);
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  // Hazard control
  logic [FWD_W-1:0] fwd_a;
  logic [FWD_W-1:0] fwd_b;
  logic             stall;
  logic             flush_d;
  logic             flush_x;
  logic             redirect;

  // ====================
  // Fetch
  // ====================
  word_t pc;
  word_t pc_target;
  word_t d_pc;
  inst_t d_inst;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (!stall) begin
      pc <= redirect ? pc_target : pc + 32'd4;
    end
  end

  assign imem_addr = pc;

  always_ff @(posedge clk) begin
    if (rst || flush_d) begin
      d_pc   <= '0;
      d_inst <= NOP_WORD;
    end else if (!stall) begin
      d_pc   <= pc;
      d_inst <= imem_data;
    end
  end

  // ====================
  // Decode
  // ====================
  reg_idx_t              d_rd;
  reg_idx_t              d_rs1;
  reg_idx_t              d_rs2;
  word_t                 d_imm;
  word_t                 d_rs1_data;
  word_t                 d_rs2_data;
  logic [ALU_OP_W-1:0]   d_alu_op;
  logic [BR_OP_W-1:0]    d_br_op;
  logic                  d_use_imm;
  logic                  d_a_is_pc;
  logic                  d_reg_we;
  logic                  d_mem_rd;
  logic                  d_mem_we;
  logic                  d_is_jump;
  logic                  d_is_jalr;
  logic                  d_is_ecall;
  reg_idx_t              w_rd;
  word_t                 w_data;
  logic                  w_reg_we;

  rv_decoder i_rv_decoder (
    .inst     (d_inst),
    .rd       (d_rd),
    .rs1      (d_rs1),
    .rs2      (d_rs2),
    .imm      (d_imm),
    .alu_op   (d_alu_op),
    .br_op    (d_br_op),
    .use_imm  (d_use_imm),
    .a_is_pc  (d_a_is_pc),
    .reg_we   (d_reg_we),
    .mem_rd   (d_mem_rd),
    .mem_we   (d_mem_we),
    .is_jump  (d_is_jump),
    .is_jalr  (d_is_jalr),
    .is_ecall (d_is_ecall)
  );

  rv_regfile i_rv_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (d_rs1),
    .rs2      (d_rs2),
    .rd       (w_rd),
    .rd_data  (w_data),
    .we       (w_reg_we),
    .rs1_data (d_rs1_data),
    .rs2_data (d_rs2_data)
  );

  // Control half of the D/X register
  word_t              x_pc;
  word_t              x_inst;
  logic [BR_OP_W-1:0] x_br_op;
  logic               x_reg_we;
  logic               x_mem_rd;
  logic               x_mem_we;
  logic               x_is_jump;
  logic               x_is_jalr;
  logic               x_is_ecall;

  always_ff @(posedge clk) begin
    if (rst || flush_x) begin
      x_pc       <= '0;
      x_inst     <= NOP_WORD;
      x_br_op    <= BR_NONE;
      x_reg_we   <= 1'b0;
      x_mem_rd   <= 1'b0;
      x_mem_we   <= 1'b0;
      x_is_jump  <= 1'b0;
      x_is_jalr  <= 1'b0;
      x_is_ecall <= 1'b0;
    end else begin
      x_pc       <= d_pc;
      x_inst     <= d_inst;
      x_br_op    <= d_br_op;
      x_reg_we   <= d_reg_we;
      x_mem_rd   <= d_mem_rd;
      x_mem_we   <= d_mem_we;
      x_is_jump  <= d_is_jump;
      x_is_jalr  <= d_is_jalr;
      x_is_ecall <= d_is_ecall;
    end
  end

  // Operand half of the D/X register
  word_t               x_rs1_data;
  word_t               x_rs2_data;
  word_t               x_imm;
  reg_idx_t            x_rd;
  reg_idx_t            x_rs1;
  reg_idx_t            x_rs2;
  logic [ALU_OP_W-1:0] x_alu_op;
  logic                x_use_imm;
  logic                x_a_is_pc;

  always_ff @(posedge clk) begin
    x_rs1_data <= d_rs1_data;
    x_rs2_data <= d_rs2_data;
    x_imm      <= d_imm;
    x_rd       <= d_rd;
    x_rs1      <= d_rs1;
    x_rs2      <= d_rs2;
    x_alu_op   <= d_alu_op;
    x_use_imm  <= d_use_imm;
    x_a_is_pc  <= d_a_is_pc;
  end

  // ====================
  // Execute
  // ====================
  word_t    m_result;
  reg_idx_t m_rd;
  logic     m_reg_we;
  word_t    fwd_a_val;
  word_t    fwd_b_val;
  word_t    x_result;
  word_t    jalr_sum;
  logic     take_branch;

  assign fwd_a_val = fwd_mux(fwd_a, x_rs1_data, m_result, w_data);
  assign fwd_b_val = fwd_mux(fwd_b, x_rs2_data, m_result, w_data);

  rv_alu i_rv_alu (
    .op_a        (x_a_is_pc ? x_pc : fwd_a_val),
    .op_b        (x_use_imm ? x_imm : fwd_b_val),
    .cmp_a       (fwd_a_val),
    .cmp_b       (fwd_b_val),
    .alu_op      (x_alu_op),
    .br_op       (x_br_op),
    .result      (x_result),
    .take_branch (take_branch)
  );

  // ECALL refetches itself so nothing younger ever reaches memory
  assign redirect  = take_branch || x_is_jump || x_is_ecall;
  assign jalr_sum  = fwd_a_val + x_imm;
  assign pc_target = x_is_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : x_pc + x_imm;

  rv_hazard i_rv_hazard (
    .d_rs1    (d_rs1),
    .d_rs2    (d_rs2),
    .x_rs1    (x_rs1),
    .x_rs2    (x_rs2),
    .x_rd     (x_rd),
    .m_rd     (m_rd),
    .w_rd     (w_rd),
    .x_mem_rd (x_mem_rd),
    .m_reg_we (m_reg_we),
    .w_reg_we (w_reg_we),
    .redirect (redirect),
    .fwd_a    (fwd_a),
    .fwd_b    (fwd_b),
    .stall    (stall),
    .flush_d  (flush_d),
    .flush_x  (flush_x)
  );

  // ====================
  // Memory
  // ====================
  word_t m_pc;
  word_t m_inst;
  word_t m_wdata;
  logic  m_mem_rd;
  logic  m_mem_we;
  logic  m_is_ecall;

  always_ff @(posedge clk) begin
    if (rst) begin
      m_pc       <= '0;
      m_inst     <= NOP_WORD;
      m_reg_we   <= 1'b0;
      m_mem_rd   <= 1'b0;
      m_mem_we   <= 1'b0;
      m_is_ecall <= 1'b0;
    end else begin
      m_pc       <= x_pc;
      m_inst     <= x_inst;
      m_reg_we   <= x_reg_we;
      m_mem_rd   <= x_mem_rd;
      m_mem_we   <= x_mem_we;
      m_is_ecall <= x_is_ecall;
    end
  end

  always_ff @(posedge clk) begin
    m_result <= x_result;
    m_wdata  <= fwd_b_val;
    m_rd     <= x_rd;
  end

  assign dmem_addr  = m_result;
  assign dmem_wdata = m_wdata;
  assign dmem_we    = m_mem_we;

  a_no_store_on_load: assert property (@(posedge clk) disable iff (rst)
    !(dmem_we && m_mem_rd));

  // ====================
  // Writeback
  // ====================
  word_t w_pc;
  word_t w_inst;
  logic  w_is_ecall;

  always_ff @(posedge clk) begin
    if (rst) begin
      w_pc       <= '0;
      w_inst     <= NOP_WORD;
      w_reg_we   <= 1'b0;
      w_is_ecall <= 1'b0;
    end else begin
      w_pc       <= m_pc;
      w_inst     <= m_inst;
      w_reg_we   <= m_reg_we;
      w_is_ecall <= m_is_ecall;
    end
  end

  // Load data is picked up while still in memory
  always_ff @(posedge clk) begin
    w_data <= m_mem_rd ? dmem_rdata : m_result;
    w_rd   <= m_rd;
  end

  assign halt       = w_is_ecall;
  assign trace_pc   = w_pc;
  assign trace_inst = w_inst;

endmodule

`default_nettype wire

//--- sim/tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  localparam word_t RESET_PC = 32'h0000_0100;
  // Five cycles per program word plus reset overhead
  localparam int PROG_WORDS  = 118;
  localparam int CYCLE_LIMIT = PROG_WORDS * 5 + 100;

  logic  clk;
  logic  rst;
  logic  load_mem;
  word_t imem_addr;
  word_t imem_data;
  word_t dmem_addr;
  word_t dmem_wdata;
  logic  dmem_we;
  word_t dmem_rdata;
  logic  halt;
  word_t trace_pc;
  word_t trace_inst;

  word_t  mem [1024];
  inst_t  prog [$];
  word_t  trace_log [$];
  logic   halted;
  logic   store_after_halt;
  int     cycles = 0;
  integer seed = 32'h2423;

  rv_core #(.RESET_PC(RESET_PC)) i_rv_core (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata),
    .halt       (halt),
    .trace_pc   (trace_pc),
    .trace_inst (trace_inst)
  );

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    load_mem = 1'b0;
  end

  always #20 clk = ~clk;

  // ====================
  // Memory model
  // ====================
  assign imem_data  = mem[imem_addr[11:2]];
  assign dmem_rdata = mem[dmem_addr[11:2]];

  always @(posedge clk) begin
    if (load_mem) begin
      for (int i = 0; i < 1024; i++) begin
        mem[i] <= 32'hA5A5_0000 | word_t'(i);
      end
      for (int j = 0; j < prog.size(); j++) begin
        mem[RESET_PC[11:2] + j] <= prog[j];
      end
    end else if (dmem_we) begin
      mem[dmem_addr[11:2]] <= dmem_wdata;
    end
  end

  // Trace and halt monitor sampled mid-cycle
  always @(negedge clk) begin
    if (rst) begin
      trace_log.delete();
      halted           <= 1'b0;
      store_after_halt <= 1'b0;
    end else begin
      if (trace_pc != '0) begin
        trace_log.push_back(trace_pc);
      end
      if (halt) begin
        halted <= 1'b1;
      end
      if ((halt || halted) && dmem_we) begin
        store_after_halt <= 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Simulation FAILED");
      $fatal(1, "Run exceeded %0d cycles without finishing", CYCLE_LIMIT);
    end
  end

  // ====================
  // Compare tasks
  // ====================
  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic check_not_traced(input word_t pc);
    foreach (trace_log[i]) begin
      if (trace_log[i] == pc) begin
        $display("A skipped instruction at pc 0x%h reached writeback", pc);
        $display("Simulation FAILED");
        $fatal(1, "Wrong path executed");
      end
    end
  endtask

  function automatic word_t data_word(input word_t addr);
    return mem[addr[11:2]];
  endfunction

  // ====================
  // Encoders
  // ====================
  function automatic inst_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input logic [2:0] f3,
                                  input reg_idx_t rd);
    inst_t w;
    w.r_fmt.funct7 = f7;
    w.r_fmt.rs2    = rs2;
    w.r_fmt.rs1    = rs1;
    w.r_fmt.funct3 = f3;
    w.r_fmt.rd     = rd;
    w.r_fmt.opcode = OP_REG;
    return w;
  endfunction

  function automatic inst_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd,
                                  input logic [6:0] op);
    inst_t w;
    w.i_fmt.imm    = imm;
    w.i_fmt.rs1    = rs1;
    w.i_fmt.funct3 = f3;
    w.i_fmt.rd     = rd;
    w.i_fmt.opcode = op;
    return w;
  endfunction

  function automatic inst_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                  input reg_idx_t rs1);
    inst_t w;
    w.s_fmt.imm_hi = imm[11:5];
    w.s_fmt.rs2    = rs2;
    w.s_fmt.rs1    = rs1;
    w.s_fmt.funct3 = 3'b010;
    w.s_fmt.imm_lo = imm[4:0];
    w.s_fmt.opcode = OP_STORE;
    return w;
  endfunction

  function automatic inst_t enc_b(input logic [12:0] off, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input logic [2:0] f3);
    inst_t w;
    w.b_fmt.imm_12   = off[12];
    w.b_fmt.imm_10_5 = off[10:5];
    w.b_fmt.rs2      = rs2;
    w.b_fmt.rs1      = rs1;
    w.b_fmt.funct3   = f3;
    w.b_fmt.imm_4_1  = off[4:1];
    w.b_fmt.imm_11   = off[11];
    w.b_fmt.opcode   = OP_BRANCH;
    return w;
  endfunction

  function automatic inst_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
                                  input logic [6:0] op);
    inst_t w;
    w.u_fmt.imm    = imm;
    w.u_fmt.rd     = rd;
    w.u_fmt.opcode = op;
    return w;
  endfunction

  function automatic inst_t enc_j(input logic [20:0] off, input reg_idx_t rd);
    inst_t w;
    w.j_fmt.imm_20    = off[20];
    w.j_fmt.imm_10_1  = off[10:1];
    w.j_fmt.imm_11    = off[11];
    w.j_fmt.imm_19_12 = off[19:12];
    w.j_fmt.rd        = rd;
    w.j_fmt.opcode    = OP_JAL;
    return w;
  endfunction

  function automatic word_t next_pc();
    return RESET_PC + 32'(4 * prog.size());
  endfunction

  task automatic emit(input inst_t w);
    prog.push_back(w);
  endtask

  task automatic emit_addi(input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm);
    emit(enc_i(imm, rs1, 3'b000, rd, OP_IMM));
  endtask

  task automatic emit_sw(input reg_idx_t src, input logic [11:0] off);
    emit(enc_s(off, src, 5'd0));
  endtask

  // LUI then ADDI with the upper part rounded for the sign of the low 12 bits
  task automatic emit_const(input reg_idx_t rd, input word_t v);
    emit(enc_u(v[31:12] + 20'(v[11]), rd, OP_LUI));
    emit_addi(rd, rd, v[11:0]);
  endtask

  // ====================
  // Run control
  // ====================
  task automatic start_program();
    @(posedge clk);
    rst      <= 1'b1;
    load_mem <= 1'b1;
    @(posedge clk);
    load_mem <= 1'b0;
    @(posedge clk);
    @(posedge clk);
    @(negedge clk);
    check_bit("halt", halt, 1'b0);
    check_bit("dmem_we", dmem_we, 1'b0);
    @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic wait_halt();
    do begin
      @(negedge clk);
    end while (!halt);
  endtask

  // ====================
  // Tests
  // ====================
  task automatic test_reset_latency();
    prog.delete();
    emit_addi(5'd1, 5'd0, 12'd1);
    emit_addi(5'd2, 5'd1, 12'd2);
    emit_sw(5'd2, 12'h400);
    emit(32'h0000_0073);
    start_program();
    @(negedge clk);
    check_word("imem_addr", imem_addr, RESET_PC);
    check_bit("halt", halt, 1'b0);
    check_bit("dmem_we", dmem_we, 1'b0);
    check_word("trace_pc", trace_pc, '0);
    for (int c = 1; c < 4; c++) begin
      @(negedge clk);
      check_word("trace_pc", trace_pc, '0);
      check_word("trace_inst", trace_inst, NOP_WORD);
    end
    @(negedge clk);
    check_word("trace_pc", trace_pc, RESET_PC);
    check_word("trace_inst", trace_inst, prog[0]);
    wait_halt();
    check_word("mem[0x400]", data_word(32'h400), 32'd3);
  endtask

  task automatic test_alu_chain();
    word_t r1;
    word_t r2;
    word_t e [10];
    r1 = $random(seed);
    r2 = $random(seed);
    e[0] = r1 + r2;
    e[1] = e[0] - r1;
    e[2] = e[1] & e[0];
    e[3] = e[2] | r2;
    e[4] = e[3] ^ r1;
    e[5] = e[4] << r2[4:0];
    e[6] = e[5] >> r1[4:0];
    e[7] = $signed(e[4]) >>> r2[4:0];
    e[8] = ($signed(e[7]) < $signed(r1)) ? 32'd1 : 32'd0;
    e[9] = (r1 < r2) ? 32'd1 : 32'd0;
    prog.delete();
    emit_const(5'd1, r1);
    emit_const(5'd2, r2);
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    emit(enc_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
    emit(enc_r(7'h00, 5'd3, 5'd4, 3'b111, 5'd5));
    emit(enc_r(7'h00, 5'd2, 5'd5, 3'b110, 5'd6));
    emit(enc_r(7'h00, 5'd1, 5'd6, 3'b100, 5'd7));
    emit(enc_r(7'h00, 5'd2, 5'd7, 3'b001, 5'd8));
    emit(enc_r(7'h00, 5'd1, 5'd8, 3'b101, 5'd9));
    emit(enc_r(7'h20, 5'd2, 5'd7, 3'b101, 5'd10));
    emit(enc_r(7'h00, 5'd1, 5'd10, 3'b010, 5'd11));
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd12));
    for (int k = 0; k < 10; k++) begin
      emit_sw(reg_idx_t'(k + 3), 12'(32'h400 + 4 * k));
    end
    emit(32'h0000_0073);
    start_program();
    wait_halt();
    for (int k = 0; k < 10; k++) begin
      check_word($sformatf("alu x%0d", k + 3), data_word(32'h400 + 4 * k), e[k]);
    end
  endtask

  task automatic test_load_use();
    word_t v;
    v = $random(seed);
    prog.delete();
    emit_const(5'd1, v);
    emit_sw(5'd1, 12'h400);
    emit(enc_i(12'h400, 5'd0, 3'b010, 5'd2, OP_LOAD));
    emit_addi(5'd3, 5'd2, 12'h123);
    emit_sw(5'd3, 12'h404);
    emit(32'h0000_0073);
    start_program();
    wait_halt();
    check_word("load_use sum", data_word(32'h404), v + 32'h123);
  endtask

  task automatic test_branches();
    logic [2:0] f3 [6];
    reg_idx_t   ra [12];
    reg_idx_t   rb [12];
    word_t      p;
    word_t      skipped [$];
    // x1 = 5 and x2 = -3 and x3 = 5
    // Even entries take the branch
    f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    ra = '{5'd1, 5'd1, 5'd1, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2, 5'd1, 5'd2, 5'd2, 5'd1};
    rb = '{5'd3, 5'd2, 5'd2, 5'd3, 5'd1, 5'd2, 5'd2, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};
    prog.delete();
    emit_addi(5'd1, 5'd0, 12'd5);
    emit_addi(5'd2, 5'd0, 12'hFFD);
    emit_addi(5'd3, 5'd0, 12'd5);
    for (int k = 0; k < 12; k++) begin
      p = next_pc();
      emit(enc_b(13'd12, rb[k], ra[k], f3[k / 2]));
      emit_addi(5'd10, 5'd0, 12'd1);
      emit(enc_j(21'd8, 5'd0));
      emit_addi(5'd10, 5'd0, 12'd2);
      emit_sw(5'd10, 12'(32'h400 + 4 * k));
      if (k % 2 == 0) begin
        skipped.push_back(p + 4);
        skipped.push_back(p + 8);
      end else begin
        skipped.push_back(p + 12);
      end
    end
    emit(32'h0000_0073);
    start_program();
    wait_halt();
    for (int k = 0; k < 12; k++) begin
      check_word($sformatf("branch case %0d", k), data_word(32'h400 + 4 * k),
                 (k % 2 == 0) ? 32'd2 : 32'd1);
    end
    foreach (skipped[i]) begin
      check_not_traced(skipped[i]);
    end
  endtask

  task automatic test_jumps_upper();
    prog.delete();
    emit(enc_j(21'd8, 5'd1));
    emit_addi(5'd7, 5'd0, 12'd1);
    emit_sw(5'd1, 12'h400);
    emit_addi(5'd2, 5'd0, 12'(RESET_PC + 24));
    emit(enc_i(12'd1, 5'd2, 3'b000, 5'd3, OP_JALR));
    emit_addi(5'd7, 5'd0, 12'd2);
    emit_sw(5'd3, 12'h404);
    emit_sw(5'd7, 12'h408);
    emit(enc_u(20'hABCDE, 5'd4, OP_LUI));
    emit(enc_u(20'h12345, 5'd5, OP_AUIPC));
    emit_sw(5'd4, 12'h40C);
    emit_sw(5'd5, 12'h410);
    emit(32'h0000_0073);
    start_program();
    wait_halt();
    check_word("jal link", data_word(32'h400), RESET_PC + 4);
    check_word("jalr link", data_word(32'h404), RESET_PC + 20);
    check_word("skipped x7", data_word(32'h408), 32'd0);
    check_word("lui x4", data_word(32'h40C), 32'hABCD_E000);
    check_word("auipc x5", data_word(32'h410), RESET_PC + 36 + 32'h1234_5000);
    check_not_traced(RESET_PC + 4);
    check_not_traced(RESET_PC + 20);
  endtask

  task automatic test_halt();
    prog.delete();
    emit_addi(5'd1, 5'd0, 12'h055);
    emit_sw(5'd1, 12'h400);
    emit(32'h0000_0073);
    emit_sw(5'd1, 12'h404);
    emit_sw(5'd1, 12'h408);
    start_program();
    wait_halt();
    repeat (8) @(negedge clk);
    check_word("mem[0x400]", data_word(32'h400), 32'h55);
    check_word("mem[0x404]", data_word(32'h404), 32'hA5A5_0000 | (32'h404 >> 2));
    check_word("mem[0x408]", data_word(32'h408), 32'hA5A5_0000 | (32'h408 >> 2));
    check_bit("store after halt", store_after_halt, 1'b0);
  endtask

  initial begin
    test_reset_latency();
    test_alu_chain();
    test_load_use();
    test_branches();
    test_jumps_upper();
    test_halt();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
src/rv_isa_pkg.sv
src/rv_ctrl_pkg.sv
src/rv_regfile.sv
src/rv_decoder.sv
src/rv_alu.sv
src/rv_hazard.sv
src/rv_core.sv
sim/tb_rv_core.sv

//--- run.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f files.f \
  --top-module tb_rv_core \
  -o tb_rv_core

./obj_dir/tb_rv_core
